/* source/noc_macros.svh */
`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// virtual channels behind one output port
`define NOC_VC_NUM 4

// downstream buffer slots per vc
`define NOC_CREDIT_DEPTH 4

// index width, kept at one bit for a single vc
`define NOC_VC_BIN_W ((`NOC_VC_NUM > 1) ? $clog2(`NOC_VC_NUM) : 1)

// holds 0 .. NOC_CREDIT_DEPTH
`define NOC_CREDIT_W $clog2(`NOC_CREDIT_DEPTH + 1)

// holds 0 .. NOC_VC_NUM
`define NOC_VC_CNT_W $clog2(`NOC_VC_NUM + 1)

`endif

/* source/noc_pkg.sv */
`include "noc_macros.svh"

`default_nettype none

package noc_pkg;

    // one bit per vc: masks, credit returns, one-hot picks
    typedef logic [`NOC_VC_NUM-1:0] vc_onehot_t;

    // binary vc index
    typedef logic [`NOC_VC_BIN_W-1:0] vc_bin_t;

    // credit count of a single vc
    typedef logic [`NOC_CREDIT_W-1:0] credit_t;

    // number of vcs, e.g. how many still have credit
    typedef logic [`NOC_VC_CNT_W-1:0] vc_count_t;

endpackage

`default_nettype wire

/* source/noc_common.sv */
`default_nettype none

// pairwise minimum finder
// flag i is set when in[i] <= every later input and < every earlier one,
// so equal values resolve to the lowest index
module fast_minimum_number #(
    parameter int NUM_OF_INPUTS = 8,
    parameter int DATA_WIDTH = 5,
    localparam int IN_ARRAY_WIDTH = NUM_OF_INPUTS * DATA_WIDTH
) (
    input  wire logic [IN_ARRAY_WIDTH-1:0] in_array_i,
    output logic [NUM_OF_INPUTS-1:0] min_out_o
);

    if (NUM_OF_INPUTS == 1) begin : g_single
        assign min_out_o = 1'b1;      // lone input is always the minimum
    end else begin : g_matrix
        wire [DATA_WIDTH-1:0] numbers [NUM_OF_INPUTS];
        wire [NUM_OF_INPUTS-2:0] comp_array [NUM_OF_INPUTS];

        for (genvar i = 0; i < NUM_OF_INPUTS; i++) begin : g_row
            assign numbers[i] = in_array_i[i*DATA_WIDTH +: DATA_WIDTH];
            for (genvar j = 0; j < NUM_OF_INPUTS - 1; j++) begin : g_col
                if (i > j) begin : g_lower
                    // mirror of the upper half, gives strict less-than
                    assign comp_array[i][j] = ~comp_array[j][i-1];
                end else begin : g_upper
                    assign comp_array[i][j] = numbers[i] <= numbers[j+1];
                end
            end
            assign min_out_o[i] = &comp_array[i];     // wins every compare
        end
    end

endmodule

// one-hot to binary conversion
module one_hot_to_bin #(
    parameter int ONE_HOT_WIDTH = 4,
    localparam int BIN_WIDTH = (ONE_HOT_WIDTH > 1) ? $clog2(ONE_HOT_WIDTH) : 1
) (
    input  wire logic [ONE_HOT_WIDTH-1:0] one_hot_code_i,
    output logic [BIN_WIDTH-1:0] bin_code_o
);

    always_comb begin
        bin_code_o = '0;
        for (int i = 0; i < ONE_HOT_WIDTH; i++) begin
            if (one_hot_code_i[i]) begin
                bin_code_o = bin_code_o | BIN_WIDTH'(i);  // or in the index
            end
        end
    end

endmodule

// population count as a ripple adder chain
module set_bits_counter #(
    parameter int IN_WIDTH = 8,
    localparam int OUT_WIDTH = $clog2(IN_WIDTH + 1)
) (
    input  wire logic [IN_WIDTH-1:0] in_i,
    output logic [OUT_WIDTH-1:0] out_o
);

    wire [OUT_WIDTH-1:0] partial [IN_WIDTH];     // running sum after bit i

    assign partial[0] = OUT_WIDTH'(in_i[0]);

    for (genvar i = 1; i < IN_WIDTH; i++) begin : g_chain
        assign partial[i] = partial[i-1] + OUT_WIDTH'(in_i[i]);
    end

    assign out_o = partial[IN_WIDTH-1];

endmodule

`default_nettype wire

/* source/credit_counter.sv */
`include "noc_macros.svh"

`default_nettype none

module credit_counter import noc_pkg::*; (
    input  wire logic clk,
    input  wire logic reset_i,
    input  wire vc_onehot_t take_onehot_i,   // credit consumed by a grant
    input  wire vc_onehot_t credit_in_i,     // credit returned downstream
    output vc_onehot_t has_credit_o,
    output credit_t [`NOC_VC_NUM-1:0] used_slots_o
);

    localparam credit_t FULL = credit_t'(`NOC_CREDIT_DEPTH);

    credit_t [`NOC_VC_NUM-1:0] credit_q;

    // a return and a take on the same vc cancel out
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int v = 0; v < `NOC_VC_NUM; v++) begin
                credit_q[v] <= FULL;          // downstream buffers start empty
            end
        end else begin
            for (int v = 0; v < `NOC_VC_NUM; v++) begin
                credit_q[v] <= credit_q[v]
                               + credit_t'(credit_in_i[v])
                               - credit_t'(take_onehot_i[v]);
            end
        end
    end

    always_comb begin
        for (int v = 0; v < `NOC_VC_NUM; v++) begin
            has_credit_o[v] = (credit_q[v] != '0);
            used_slots_o[v] = FULL - credit_q[v];   // slots held downstream
        end
    end

    for (genvar v = 0; v < `NOC_VC_NUM; v++) begin : g_chk

        // downstream may only return what was granted earlier
        a_no_overflow: assert property (
            @(posedge clk) disable iff (reset_i)
            (credit_in_i[v] && !take_onehot_i[v]) |-> (credit_q[v] < FULL)
        ) else $error("credit return overflows full vc %0d", v);

        // the allocator must only take from a vc that has credit
        a_no_underflow: assert property (
            @(posedge clk) disable iff (reset_i)
            take_onehot_i[v] |-> (credit_q[v] != '0)
        ) else $error("take from empty vc %0d", v);

    end

endmodule

`default_nettype wire

/* source/least_loaded_pick.sv */
`include "noc_macros.svh"

`default_nettype none

module least_loaded_pick import noc_pkg::*; (
    input  wire vc_onehot_t has_credit_i,
    input  wire credit_t [`NOC_VC_NUM-1:0] used_slots_i,
    output vc_onehot_t pick_onehot_o,
    output vc_bin_t pick_bin_o
);

    // an eligible vc always has used < depth, so this code never ties with it
    localparam credit_t MAX_CODE = '1;

    credit_t [`NOC_VC_NUM-1:0] masked_used;

    always_comb begin
        for (int v = 0; v < `NOC_VC_NUM; v++) begin
            // empty vcs pushed to the back of the order
            masked_used[v] = has_credit_i[v] ? used_slots_i[v] : MAX_CODE;
        end
    end

    // fewest used slots means most credits left
    fast_minimum_number #(
        .NUM_OF_INPUTS(`NOC_VC_NUM),
        .DATA_WIDTH   (`NOC_CREDIT_W)
    ) u_min (
        .in_array_i(masked_used),
        .min_out_o (pick_onehot_o)
    );

    one_hot_to_bin #(
        .ONE_HOT_WIDTH(`NOC_VC_NUM)
    ) u_to_bin (
        .one_hot_code_i(pick_onehot_o),
        .bin_code_o    (pick_bin_o)
    );

    // single winner, and it has credit whenever any vc does
    always_comb begin
        a_pick_valid: assert final (
            $onehot0(pick_onehot_o) &&
            (!(|has_credit_i) || ((pick_onehot_o & has_credit_i) != '0))
        ) else $error("bad vc pick %b for credit mask %b",
                      pick_onehot_o, has_credit_i);
    end

endmodule

`default_nettype wire

/* source/vc_allocator.sv */
`include "noc_macros.svh"

`default_nettype none

module vc_allocator import noc_pkg::*; (
    input  wire logic clk,
    input  wire logic reset_i,
    input  wire logic req_i,              // one request per high cycle
    input  wire vc_onehot_t has_credit_i,
    input  wire vc_bin_t pick_bin_i,
    output vc_onehot_t take_onehot_o,     // credit consumed this edge
    output logic grant_valid_o,
    output vc_bin_t grant_vc_o,
    output logic blocked_o,
    output vc_count_t free_vc_count_o
);

    logic any_credit;
    logic accept;

    assign any_credit = |has_credit_i;
    assign accept = req_i && any_credit;

    // decode the pick so the counter drops it at the grant edge
    always_comb begin
        take_onehot_o = '0;
        if (accept) begin
            take_onehot_o = vc_onehot_t'(1) << pick_bin_i;
        end
    end

    // grant or blocked one cycle after the request
    always_ff @(posedge clk) begin
        if (reset_i) begin
            grant_valid_o <= 1'b0;
            blocked_o <= 1'b0;
            grant_vc_o <= '0;
        end else begin
            grant_valid_o <= accept;
            blocked_o <= req_i && !any_credit;  // dropped, not retried
            if (accept) begin
                grant_vc_o <= pick_bin_i;       // hold last vc otherwise
            end
        end
    end

    set_bits_counter #(
        .IN_WIDTH(`NOC_VC_NUM)
    ) u_free_cnt (
        .in_i (has_credit_i),
        .out_o(free_vc_count_o)
    );

    // every request ends in exactly one outcome, next cycle
    a_one_outcome: assert property (
        @(posedge clk) disable iff (reset_i)
        req_i |=> (grant_valid_o != blocked_o)
    ) else $error("request without a single grant/blocked outcome");

    // no spurious pulse without a request
    a_no_spurious: assert property (
        @(posedge clk) disable iff (reset_i)
        !req_i |=> !(grant_valid_o || blocked_o)
    ) else $error("grant or blocked pulse without request");

endmodule

`default_nettype wire

/* source/outport_vc_select.sv */
`include "noc_macros.svh"

`default_nettype none

module outport_vc_select import noc_pkg::*; (
    input  wire logic clk,
    input  wire logic reset_i,
    input  wire logic req_i,
    input  wire vc_onehot_t credit_in_i,
    output logic grant_valid_o,
    output vc_bin_t grant_vc_o,
    output logic blocked_o,
    output vc_count_t free_vc_count_o
);

    vc_onehot_t has_credit;
    credit_t [`NOC_VC_NUM-1:0] used_slots;
    vc_bin_t pick_bin;
    vc_onehot_t take_onehot;

    credit_counter u_credit_counter (
        .clk          (clk),
        .reset_i      (reset_i),
        .take_onehot_i(take_onehot),
        .credit_in_i  (credit_in_i),
        .has_credit_o (has_credit),
        .used_slots_o (used_slots)
    );

    least_loaded_pick u_least_loaded_pick (
        .has_credit_i (has_credit),
        .used_slots_i (used_slots),
        .pick_onehot_o(),
        .pick_bin_o   (pick_bin)
    );

    vc_allocator u_vc_allocator (
        .clk            (clk),
        .reset_i        (reset_i),
        .req_i          (req_i),
        .has_credit_i   (has_credit),
        .pick_bin_i     (pick_bin),
        .take_onehot_o  (take_onehot),
        .grant_valid_o  (grant_valid_o),
        .grant_vc_o     (grant_vc_o),
        .blocked_o      (blocked_o),
        .free_vc_count_o(free_vc_count_o)
    );

endmodule

`default_nettype wire

/* verif/outport_vc_select_checker.sv */
`include "noc_macros.svh"

`default_nettype none

module outport_vc_select_checker import noc_pkg::*; (
    input  wire logic clk_i,
    input  wire logic reset_i,
    input  wire logic req_i,
    input  wire vc_onehot_t credit_in_i,
    input  wire logic grant_valid_i,
    input  wire vc_bin_t grant_vc_i,
    input  wire logic blocked_i,
    input  wire vc_count_t free_vc_count_i,
    input  wire logic row_check_i,          // a table row applies to this cycle
    input  wire logic exp_grant_valid_i,
    input  wire vc_bin_t exp_grant_vc_i,
    input  wire logic exp_blocked_i,
    input  wire vc_count_t exp_free_i,
    output vc_onehot_t model_full_o,        // vcs at full depth in the model
    output int checks_o,
    output int errors_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int credit [`NOC_VC_NUM];               // reference credit per vc
    logic armed = 1'b0;
    logic want_valid;
    logic want_blocked;
    vc_bin_t want_vc;
    logic row_armed;
    logic row_gv;
    vc_bin_t row_vc;
    logic row_blk;
    vc_count_t row_free;
    int checks = 0;
    int errors = 0;

    assign checks_o = checks;
    assign errors_o = errors;

    // most credits wins, lowest index on a tie, -1 when all are empty
    function automatic int best_vc();
        int best;
        best = -1;
        for (int v = 0; v < `NOC_VC_NUM; v++) begin
            if (credit[v] > 0 && (best < 0 || credit[v] > credit[best])) begin
                best = v;
            end
        end
        return best;
    endfunction

    function automatic int count_free();
        int n;
        n = 0;
        for (int v = 0; v < `NOC_VC_NUM; v++) begin
            if (credit[v] > 0) n++;
        end
        return n;
    endfunction

    task automatic check_value(input string sig, input string src, input int expected,
                               input int actual);
        if (expected != actual) begin
            errors++;
            $display("Error at %0d ns: %s expected %0d (%s), got %0d",
                     $time, sig, expected, src, actual);
        end
    endtask

    always_comb begin
        for (int v = 0; v < `NOC_VC_NUM; v++) begin
            model_full_o[v] = (credit[v] >= `NOC_CREDIT_DEPTH);
        end
    end

    // reference model steps at the same edge as the DUT
    always @(posedge clk_i) begin : model_step
        int pick;
        if (reset_i) begin
            for (int v = 0; v < `NOC_VC_NUM; v++) begin
                credit[v] <= `NOC_CREDIT_DEPTH;
            end
            want_valid <= 1'b0;
            want_blocked <= 1'b0;
            want_vc <= '0;
            armed <= 1'b0;
            row_armed <= 1'b0;
        end else begin
            pick = best_vc();
            want_valid <= req_i && (pick >= 0);
            want_blocked <= req_i && (pick < 0);   // dropped request
            if (req_i && pick >= 0) begin
                want_vc <= vc_bin_t'(pick);
            end
            for (int v = 0; v < `NOC_VC_NUM; v++) begin
                credit[v] <= credit[v] + int'(credit_in_i[v])
                             - ((req_i && pick == v) ? 1 : 0);
            end
            armed <= 1'b1;
            row_armed <= row_check_i;
            row_gv <= exp_grant_valid_i;
            row_vc <= exp_grant_vc_i;
            row_blk <= exp_blocked_i;
            row_free <= exp_free_i;
        end
    end

    // outputs settle after the rising edge, compare half a cycle later
    always @(negedge clk_i) begin
        if (!reset_i && armed) begin
            checks++;
            check_value("grant_valid_o", "model", int'(want_valid), int'(grant_valid_i));
            check_value("blocked_o", "model", int'(want_blocked), int'(blocked_i));
            if (want_valid) begin
                check_value("grant_vc_o", "model", int'(want_vc), int'(grant_vc_i));
            end
            check_value("free_vc_count_o", "model", count_free(), int'(free_vc_count_i));
            if (row_armed) begin
                check_value("grant_valid_o", "table", int'(row_gv), int'(grant_valid_i));
                check_value("blocked_o", "table", int'(row_blk), int'(blocked_i));
                if (row_gv) begin
                    check_value("grant_vc_o", "table", int'(row_vc), int'(grant_vc_i));
                end
                check_value("free_vc_count_o", "table", int'(row_free),
                            int'(free_vc_count_i));
            end
        end
    end

endmodule

`default_nettype wire

/* verif/outport_vc_select_tb.sv */
`include "noc_macros.svh"

`default_nettype none

module outport_vc_select_tb import noc_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 8;
    localparam int RAND_CYCLES = 200;

    typedef struct packed {
        int test_id;
        logic req;
        vc_onehot_t cin;
        logic gv;
        vc_bin_t vc;
        logic blk;
        vc_count_t free_cnt;
    } row_t;

    logic clk;
    logic reset;
    logic req;
    vc_onehot_t credit_in;
    logic grant_valid;
    vc_bin_t grant_vc;
    logic blocked;
    vc_count_t free_vc_count;
    logic row_check;
    logic exp_grant_valid;
    vc_bin_t exp_grant_vc;
    logic exp_blocked;
    vc_count_t exp_free;
    vc_onehot_t model_full;
    int checks;
    int errors;
    row_t rows[$];
    bit table_ready = 1'b0;
    int seed = 28;

    outport_vc_select outport_vc_select_i (
        .clk            (clk),
        .reset_i        (reset),
        .req_i          (req),
        .credit_in_i    (credit_in),
        .grant_valid_o  (grant_valid),
        .grant_vc_o     (grant_vc),
        .blocked_o      (blocked),
        .free_vc_count_o(free_vc_count)
    );

    outport_vc_select_checker monitor_i (
        .clk_i            (clk),
        .reset_i          (reset),
        .req_i            (req),
        .credit_in_i      (credit_in),
        .grant_valid_i    (grant_valid),
        .grant_vc_i       (grant_vc),
        .blocked_i        (blocked),
        .free_vc_count_i  (free_vc_count),
        .row_check_i      (row_check),
        .exp_grant_valid_i(exp_grant_valid),
        .exp_grant_vc_i   (exp_grant_vc),
        .exp_blocked_i    (exp_blocked),
        .exp_free_i       (exp_free),
        .model_full_o     (model_full),
        .checks_o         (checks),
        .errors_o         (errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic string test_name(input int id);
        case (id)
            1: return "reset values";
            2: return "least-loaded order";
            3: return "credit returns";
            4: return "exhaustion";
            default: return "random traffic";
        endcase
    endfunction

    task automatic add_row(input int id, input int r, input int cin, input int gv,
                           input int vc, input int blk, input int free_cnt);
        row_t row;
        row.test_id = id;
        row.req = (r != 0);
        row.cin = vc_onehot_t'(cin);
        row.gv = (gv != 0);
        row.vc = vc_bin_t'(vc);
        row.blk = (blk != 0);
        row.free_cnt = vc_count_t'(free_cnt);
        rows.push_back(row);
    endtask

    // id, req, credit_in, grant_valid, grant_vc, blocked, free count
    task automatic build_table();
        add_row(1, 0, 'b0000, 0, 0, 0, 4);
        add_row(1, 0, 'b0000, 0, 0, 0, 4);
        add_row(2, 1, 'b0000, 1, 0, 0, 4);
        add_row(2, 1, 'b0000, 1, 1, 0, 4);
        add_row(2, 1, 'b0000, 1, 2, 0, 4);
        add_row(2, 1, 'b0000, 1, 3, 0, 4);
        add_row(2, 1, 'b0000, 1, 0, 0, 4);   // credits 2,3,3,3
        add_row(3, 0, 'b0001, 0, 0, 0, 4);
        add_row(3, 1, 'b0000, 1, 0, 0, 4);
        add_row(3, 0, 'b1000, 0, 0, 0, 4);   // vc3 back to full
        add_row(3, 1, 'b0000, 1, 3, 0, 4);
        add_row(3, 1, 'b0010, 1, 1, 0, 4);   // return and take cancel
        add_row(3, 1, 'b0010, 1, 1, 0, 4);
        add_row(4, 1, 'b0000, 1, 1, 0, 4);
        add_row(4, 1, 'b0000, 1, 2, 0, 4);
        add_row(4, 1, 'b0000, 1, 3, 0, 4);
        add_row(4, 1, 'b0000, 1, 0, 0, 4);
        add_row(4, 1, 'b0000, 1, 1, 0, 4);
        add_row(4, 1, 'b0000, 1, 2, 0, 4);
        add_row(4, 1, 'b0000, 1, 3, 0, 4);   // one credit left on each vc
        add_row(4, 1, 'b0000, 1, 0, 0, 3);
        add_row(4, 1, 'b0000, 1, 1, 0, 2);
        add_row(4, 1, 'b0000, 1, 2, 0, 1);
        add_row(4, 1, 'b0000, 1, 3, 0, 0);
        add_row(4, 1, 'b0000, 0, 0, 1, 0);
        add_row(4, 1, 'b0000, 0, 0, 1, 0);
        add_row(4, 0, 'b0100, 0, 0, 0, 1);
        add_row(4, 1, 'b0000, 1, 2, 0, 0);
        add_row(4, 1, 'b0001, 0, 0, 1, 1);   // return lands after the blocked edge
        add_row(4, 1, 'b0000, 1, 0, 0, 0);
    endtask

    task automatic drive_row(input row_t row);
        @(negedge clk);
        req = row.req;
        credit_in = row.cin;
        row_check = 1'b1;
        exp_grant_valid = row.gv;
        exp_grant_vc = row.vc;
        exp_blocked = row.blk;
        exp_free = row.free_cnt;
    endtask

    task automatic drive_idle();
        @(negedge clk);
        req = 1'b0;
        credit_in = '0;
        row_check = 1'b0;
    endtask

    // idle cycle lets the last row be compared before the count is read
    task automatic finish_test(input int id, input int errors_before);
        drive_idle();
        @(posedge clk);
        $display("test %0d %s finished with %0d error(s)", id, test_name(id),
                 errors - errors_before);
    endtask

    task automatic run_table_test(input int id);
        int errors_before;
        errors_before = errors;
        foreach (rows[k]) begin
            if (rows[k].test_id == id) drive_row(rows[k]);
        end
        finish_test(id, errors_before);
    endtask

    task automatic run_random_test();
        int errors_before;
        logic [31:0] rnd;
        errors_before = errors;
        for (int n = 0; n < RAND_CYCLES; n++) begin
            @(negedge clk);
            rnd = $random(seed);
            req = rnd[0] | rnd[1];             // about three requests in four
            rnd = $random(seed);
            credit_in = rnd[`NOC_VC_NUM-1:0] & rnd[`NOC_VC_NUM+7:8]
                        & rnd[`NOC_VC_NUM+15:16] & ~model_full;
            row_check = 1'b0;
        end
        finish_test(5, errors_before);
    endtask

    initial begin
        wait (table_ready);
        #((rows.size() + RAND_CYCLES + 20) * CLK_PERIOD);
        $display("simulation hung, watchdog expired at %0d ns", $time);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        req = 1'b0;
        credit_in = '0;
        row_check = 1'b0;
        exp_grant_valid = 1'b0;
        exp_grant_vc = '0;
        exp_blocked = 1'b0;
        exp_free = '0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int id = 1; id <= 4; id++) begin
            run_table_test(id);
        end
        run_random_test();
        if (checks == 0) $display("no DUT output was ever compared");
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+source
source/noc_pkg.sv
source/noc_common.sv
source/credit_counter.sv
source/least_loaded_pick.sv
source/vc_allocator.sv
source/outport_vc_select.sv
verif/outport_vc_select_checker.sv
verif/outport_vc_select_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f flist.f \
		--top-module outport_vc_select_tb -o outport_vc_select_sim
	-./obj_dir/outport_vc_select_sim > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "Test OK" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
